//--- usb_sie_config.svh
// Endpoint numbers, CRC polynomials, CRC16 residue, address and frame widths.
`ifndef USB_SIE_CONFIG_SVH
`define USB_SIE_CONFIG_SVH

// Endpoint numbers handled by the engine.
`define USB_ENDP_CTRL 4'd0
`define USB_ENDP_BULK 4'd1

// CRC generator polynomials, high-order term implied.
`define USB_CRC5_POLY 5'b00101
`define USB_CRC16_POLY 16'h8005

// Register value left after data, CRC high and CRC low bytes.
`define USB_CRC16_RESI 16'h800D

// Device address and frame number widths.
`define USB_ADDR_W 7
`define USB_FRAME_W 11

`endif

//--- usb_sie_pkg.sv
// PID encodings, token payload union and the USB CRC5 and CRC16 functions.
`include "usb_sie_config.svh"

package usb_sie_pkg;

   // Packet identifiers, lower nibble as sent on the bus.
   typedef enum logic [3:0] {
      PID_RESERVED = 4'b0000,
      PID_OUT      = 4'b0001,
      PID_IN       = 4'b1001,
      PID_SOF      = 4'b0101,
      PID_SETUP    = 4'b1101,
      PID_DATA0    = 4'b0011,
      PID_DATA1    = 4'b1011,
      PID_ACK      = 4'b0010,
      PID_NAK      = 4'b1010,
      PID_STALL    = 4'b1110
   } pid_e;

   // The 11 token bits are a frame number for SOF, else endpoint and address.
   typedef union packed {
      logic [`USB_FRAME_W-1:0] frame;
      struct packed {
         logic [3:0]             endp;
         logic [`USB_ADDR_W-1:0] addr;
      } dev;
   } token_u;

   // Returns the 5-bit field as it appears on the bus after the payload.
   function automatic logic [4:0] crc5(input logic [`USB_FRAME_W-1:0] data);
      logic [4:0] crc;
      logic [4:0] field;
      crc = 5'b11111;
      for (int i = 0; i < `USB_FRAME_W; i++) begin
         if ((data[i] ^ crc[4]) == 1'b1) begin
            crc = {crc[3:0], 1'b0} ^ `USB_CRC5_POLY;
         end else begin
            crc = {crc[3:0], 1'b0};
         end
      end
      // Sent inverted, most significant bit first.
      for (int i = 0; i < 5; i++) begin
         field[i] = ~crc[4-i];
      end
      return field;
   endfunction

   // One byte step of the running CRC16, bits taken LSB first.
   function automatic logic [15:0] crc16(input logic [7:0]  data,
                                         input logic [15:0] crc_in);
      logic [15:0] crc;
      crc = crc_in;
      for (int i = 0; i < 8; i++) begin
         if ((data[i] ^ crc[15]) == 1'b1) begin
            crc = {crc[14:0], 1'b0} ^ `USB_CRC16_POLY;
         end else begin
            crc = {crc[14:0], 1'b0};
         end
      end
      return crc;
   endfunction

endpackage

//--- usb_rx_packet.sv
// Receive decoder: PID check, token CRC5, data CRC16 and byte streaming.
`timescale 1ns/1ns
`include "usb_sie_config.svh"

module usb_rx_packet
   import usb_sie_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    rstn,
   input  logic [7:0]              rx_data_i,
   input  logic                    rx_valid_i,
   input  logic                    rx_err_i,
   input  logic                    rx_ready_i,
   input  logic                    tx_busy_i,
   input  logic                    data_accept_i,
   output logic                    tok_valid_o,
   output pid_e                    tok_pid_o,
   output token_u                  tok_payload_o,
   output logic                    data_start_o,
   output pid_e                    data_pid_o,
   output logic [7:0]              data_byte_o,
   output logic                    data_byte_valid_o,
   output logic                    data_end_o,
   output logic                    crc_ok_o,
   output logic                    rx_abort_o
);

   localparam logic [2:0] ST_IDLE       = 3'd0;
   localparam logic [2:0] ST_PID        = 3'd1;
   localparam logic [2:0] ST_TOK1       = 3'd2;
   localparam logic [2:0] ST_TOK2       = 3'd3;
   localparam logic [2:0] ST_DATA_FIRST = 3'd4;
   localparam logic [2:0] ST_DATA       = 3'd5;
   localparam logic [2:0] ST_WAIT_END   = 3'd6;

   logic [2:0]              state_q;
   logic [2:0]              state_d;
   logic                    step;
   logic [15:0]             shift_q;
   logic [15:0]             crc_q;
   logic [15:0]             crc_next;
   logic                    pid_ok;
   logic [`USB_FRAME_W-1:0] tok_bits;
   logic                    crc5_ok;
   pid_e                    pid_q;
   token_u                  tok_payload_q;
   logic [7:0]              data_byte_q;
   logic                    crc_ok_q;
   logic                    tok_valid_d;
   logic                    tok_valid_q;
   logic                    start_d;
   logic                    start_q;
   logic                    byte_valid_d;
   logic                    byte_valid_q;
   logic                    end_d;
   logic                    end_q;
   logic                    abort_d;
   logic                    abort_q;

   // Receive steps are held off while a handshake is pending.
   assign step = rx_ready_i & ~tx_busy_i;

   // In ST_PID the low byte of the shift register is the PID byte.
   assign pid_ok = (shift_q[7:4] == ~shift_q[3:0]);

   // In ST_TOK2 the register holds both token bytes, first one on top.
   assign tok_bits = {shift_q[2:0], shift_q[15:8]};
   assign crc5_ok  = (crc5(tok_bits) == shift_q[7:3]);
   assign crc_next = crc16(shift_q[7:0], crc_q);

   always_comb begin
      state_d      = state_q;
      tok_valid_d  = 1'b0;
      start_d      = 1'b0;
      byte_valid_d = 1'b0;
      end_d        = 1'b0;
      abort_d      = 1'b0;
      if (step) begin
         if (rx_err_i) begin
            state_d = ST_IDLE;
            abort_d = (state_q == ST_DATA_FIRST) || (state_q == ST_DATA);
         end else begin
            case (state_q)
               ST_IDLE: begin
                  if (rx_valid_i) begin
                     state_d = ST_PID;
                  end
               end
               ST_PID: begin
                  if (!rx_valid_i) begin
                     state_d = ST_IDLE;
                  end else if (!pid_ok) begin
                     state_d = ST_WAIT_END;
                  end else if (shift_q[1:0] == 2'b01) begin
                     state_d = ST_TOK1;
                  end else if (shift_q[1:0] == 2'b11 && !shift_q[2] && data_accept_i) begin
                     // Only DATA0 and DATA1 are streamed.
                     state_d = ST_DATA_FIRST;
                     start_d = 1'b1;
                  end else begin
                     state_d = ST_WAIT_END;
                  end
               end
               ST_TOK1: begin
                  state_d = rx_valid_i ? ST_TOK2 : ST_IDLE;
               end
               ST_TOK2: begin
                  if (rx_valid_i) begin
                     state_d = ST_WAIT_END;
                  end else begin
                     state_d     = ST_IDLE;
                     tok_valid_d = crc5_ok;
                  end
               end
               ST_DATA_FIRST: begin
                  if (rx_valid_i) begin
                     state_d = ST_DATA;
                  end else begin
                     // Too short to hold a CRC, reported as bad.
                     state_d = ST_IDLE;
                     end_d   = 1'b1;
                  end
               end
               ST_DATA: begin
                  if (rx_valid_i) begin
                     byte_valid_d = 1'b1;
                  end else begin
                     state_d = ST_IDLE;
                     end_d   = 1'b1;
                  end
               end
               ST_WAIT_END: begin
                  if (!rx_valid_i) begin
                     state_d = ST_IDLE;
                  end
               end
               default: begin
                  state_d = ST_IDLE;
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         state_q      <= ST_IDLE;
         tok_valid_q  <= 1'b0;
         start_q      <= 1'b0;
         byte_valid_q <= 1'b0;
         end_q        <= 1'b0;
         abort_q      <= 1'b0;
      end else begin
         state_q      <= state_d;
         tok_valid_q  <= tok_valid_d;
         start_q      <= start_d;
         byte_valid_q <= byte_valid_d;
         end_q        <= end_d;
         abort_q      <= abort_d;
      end
   end

   // Two bytes stay in flight, so the CRC bytes are never streamed out.
   always_ff @(posedge clk_i) begin
      if (step) begin
         if (rx_valid_i) begin
            shift_q <= {shift_q[7:0], rx_data_i};
         end
         if (state_q == ST_PID) begin
            pid_q <= pid_e'(shift_q[3:0]);
            crc_q <= 16'hFFFF;
         end else if (state_q == ST_DATA_FIRST || state_q == ST_DATA) begin
            crc_q <= crc_next;
         end
         if (state_q == ST_TOK2) begin
            tok_payload_q <= token_u'(tok_bits);
         end
         if (state_q == ST_DATA) begin
            data_byte_q <= shift_q[15:8];
         end
         crc_ok_q <= (state_q == ST_DATA) && (crc_next == `USB_CRC16_RESI);
      end
   end

   assign tok_valid_o       = tok_valid_q;
   assign tok_pid_o         = pid_q;
   assign tok_payload_o     = tok_payload_q;
   assign data_start_o      = start_q;
   assign data_pid_o        = pid_q;
   assign data_byte_o       = data_byte_q;
   assign data_byte_valid_o = byte_valid_q;
   assign data_end_o        = end_q;
   assign crc_ok_o          = crc_ok_q;
   assign rx_abort_o        = abort_q;

endmodule

//--- usb_sie_ctrl.sv
// Transaction controller: address match, OUT toggles, handshakes, frame and endpoint.
`timescale 1ns/1ns
`include "usb_sie_config.svh"

module usb_sie_ctrl
   import usb_sie_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    rstn,
   input  logic                    tok_valid_i,
   input  pid_e                    tok_pid_i,
   input  token_u                  tok_payload_i,
   input  logic                    data_start_i,
   input  pid_e                    data_pid_i,
   input  logic [7:0]              data_byte_i,
   input  logic                    data_byte_valid_i,
   input  logic                    data_end_i,
   input  logic                    crc_ok_i,
   input  logic                    rx_abort_i,
   input  logic [`USB_ADDR_W-1:0]  addr_i,
   input  logic                    stall_i,
   input  logic                    out_nak_i,
   input  logic                    out_toggle_reset_i,
   input  logic                    tx_ready_i,
   output logic                    data_accept_o,
   output logic [7:0]              out_data_o,
   output logic                    out_valid_o,
   output logic                    out_eop_o,
   output logic                    out_err_o,
   output logic                    setup_o,
   output logic [3:0]              endp_o,
   output logic [`USB_FRAME_W-1:0] frame_o,
   output logic [7:0]              tx_data_o,
   output logic                    tx_valid_o
);

   logic                    tok_sof;
   logic                    tok_addr_match;
   logic                    ep_known;
   logic                    toggle_cur;
   logic                    toggle_ok;
   logic                    pkt_good;
   logic [`USB_FRAME_W-1:0] frame_q;
   logic [3:0]              endp_q;
   logic                    setup_q;
   logic                    accept_q;
   logic                    toggle_ctrl_q;
   logic                    toggle_bulk_q;
   pid_e                    data_pid_q;
   logic [7:0]              out_data_q;
   logic                    out_valid_q;
   logic                    out_eop_q;
   logic                    out_err_q;
   pid_e                    hs_pid_q;
   logic                    tx_valid_q;

   assign tok_sof        = (tok_pid_i == PID_SOF);
   assign tok_addr_match = (tok_payload_i.dev.addr == addr_i);

   assign ep_known   = (endp_q == `USB_ENDP_CTRL) || (endp_q == `USB_ENDP_BULK);
   assign toggle_cur = (endp_q == `USB_ENDP_CTRL) ? toggle_ctrl_q : toggle_bulk_q;
   // Bit 3 of the PID tells DATA1 from DATA0.
   assign toggle_ok  = (toggle_cur == data_pid_q[3]);
   assign pkt_good   = crc_ok_i && ep_known && toggle_ok;

   // Token registers.
   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         frame_q  <= '0;
         endp_q   <= `USB_ENDP_CTRL;
         setup_q  <= 1'b0;
         accept_q <= 1'b0;
      end else if (tok_valid_i) begin
         setup_q  <= (tok_pid_i == PID_SETUP);
         accept_q <= (tok_pid_i == PID_OUT || tok_pid_i == PID_SETUP) && tok_addr_match;
         if (tok_sof) begin
            frame_q <= tok_payload_i.frame;
         end else begin
            endp_q <= tok_payload_i.dev.endp;
         end
      end
   end

   // OUT data toggles; a later write in this block wins.
   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         toggle_ctrl_q <= 1'b0;
         toggle_bulk_q <= 1'b0;
      end else begin
         if (out_toggle_reset_i) begin
            toggle_bulk_q <= 1'b0;
         end
         if (tok_valid_i && tok_pid_i == PID_SETUP && tok_addr_match) begin
            toggle_ctrl_q <= 1'b0;
         end
         if (data_end_i && pkt_good && !out_nak_i) begin
            if (endp_q == `USB_ENDP_CTRL) begin
               toggle_ctrl_q <= ~toggle_ctrl_q;
            end else begin
               toggle_bulk_q <= ~toggle_bulk_q;
            end
         end
      end
   end

   // Endpoint strobes, one cycle behind the decoder events.
   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         out_valid_q <= 1'b0;
         out_eop_q   <= 1'b0;
         out_err_q   <= 1'b0;
      end else begin
         out_valid_q <= data_byte_valid_i;
         out_eop_q   <= data_end_i && pkt_good;
         out_err_q   <= (data_end_i && !pkt_good) || rx_abort_i;
      end
   end

   // Handshake is held until the PHY takes it.
   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         tx_valid_q <= 1'b0;
      end else if (data_end_i && crc_ok_i) begin
         tx_valid_q <= 1'b1;
      end else if (tx_valid_q && tx_ready_i) begin
         tx_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (data_start_i) begin
         data_pid_q <= data_pid_i;
      end
      if (data_byte_valid_i) begin
         out_data_q <= data_byte_i;
      end
      if (data_end_i) begin
         if (stall_i) begin
            hs_pid_q <= PID_STALL;
         end else if (out_nak_i) begin
            hs_pid_q <= PID_NAK;
         end else begin
            hs_pid_q <= PID_ACK;
         end
      end
   end

   assign data_accept_o = accept_q;
   assign out_data_o    = out_data_q;
   assign out_valid_o   = out_valid_q;
   assign out_eop_o     = out_eop_q;
   assign out_err_o     = out_err_q;
   assign setup_o       = setup_q;
   assign endp_o        = endp_q;
   assign frame_o       = frame_q;
   // Check nibble above the PID.
   assign tx_data_o     = {~hs_pid_q, hs_pid_q};
   assign tx_valid_o    = tx_valid_q;

endmodule

//--- usb_sie_top.sv
// Top level of the USB protocol engine: receive decoder and transaction controller.
`timescale 1ns/1ns
`include "usb_sie_config.svh"

module usb_sie_top
   import usb_sie_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    rstn,
   input  logic [7:0]              rx_data_i,
   input  logic                    rx_valid_i,
   input  logic                    rx_err_i,
   input  logic                    rx_ready_i,
   input  logic                    tx_ready_i,
   output logic [7:0]              tx_data_o,
   output logic                    tx_valid_o,
   output logic [7:0]              out_data_o,
   output logic                    out_valid_o,
   output logic                    out_eop_o,
   output logic                    out_err_o,
   output logic                    setup_o,
   output logic [3:0]              endp_o,
   output logic [`USB_FRAME_W-1:0] frame_o,
   input  logic [`USB_ADDR_W-1:0]  addr_i,
   input  logic                    stall_i,
   input  logic                    out_nak_i,
   input  logic                    out_toggle_reset_i
);

   logic       tok_valid;
   pid_e       tok_pid;
   token_u     tok_payload;
   logic       data_start;
   pid_e       data_pid;
   logic [7:0] data_byte;
   logic       data_byte_valid;
   logic       data_end;
   logic       crc_ok;
   logic       rx_abort;
   logic       data_accept;

   // The pending handshake also stalls the receive side.
   usb_rx_packet u_rx_packet (
      .clk_i             (clk_i),
      .rstn              (rstn),
      .rx_data_i         (rx_data_i),
      .rx_valid_i        (rx_valid_i),
      .rx_err_i          (rx_err_i),
      .rx_ready_i        (rx_ready_i),
      .tx_busy_i         (tx_valid_o),
      .data_accept_i     (data_accept),
      .tok_valid_o       (tok_valid),
      .tok_pid_o         (tok_pid),
      .tok_payload_o     (tok_payload),
      .data_start_o      (data_start),
      .data_pid_o        (data_pid),
      .data_byte_o       (data_byte),
      .data_byte_valid_o (data_byte_valid),
      .data_end_o        (data_end),
      .crc_ok_o          (crc_ok),
      .rx_abort_o        (rx_abort)
   );

   usb_sie_ctrl u_sie_ctrl (
      .clk_i              (clk_i),
      .rstn               (rstn),
      .tok_valid_i        (tok_valid),
      .tok_pid_i          (tok_pid),
      .tok_payload_i      (tok_payload),
      .data_start_i       (data_start),
      .data_pid_i         (data_pid),
      .data_byte_i        (data_byte),
      .data_byte_valid_i  (data_byte_valid),
      .data_end_i         (data_end),
      .crc_ok_i           (crc_ok),
      .rx_abort_i         (rx_abort),
      .addr_i             (addr_i),
      .stall_i            (stall_i),
      .out_nak_i          (out_nak_i),
      .out_toggle_reset_i (out_toggle_reset_i),
      .tx_ready_i         (tx_ready_i),
      .data_accept_o      (data_accept),
      .out_data_o         (out_data_o),
      .out_valid_o        (out_valid_o),
      .out_eop_o          (out_eop_o),
      .out_err_o          (out_err_o),
      .setup_o            (setup_o),
      .endp_o             (endp_o),
      .frame_o            (frame_o),
      .tx_data_o          (tx_data_o),
      .tx_valid_o         (tx_valid_o)
   );

endmodule

//--- tb_usb_sie_top.sv
// Testbench for the USB protocol engine with packet builders and reference CRCs.
`timescale 1ns/1ns
`include "usb_sie_config.svh"

module tb_usb_sie_top;

   // 4 cycles per strobe, 12 strobes per packet, 40 packets, margin of 2.
   localparam int CYCLE_LIMIT = 4 * 12 * 40 * 2;
   localparam logic [6:0] DEV_ADDR = 7'h2A;

   logic        clk_i = 1'b0;
   logic        rstn;
   logic [7:0]  rx_data_i;
   logic        rx_valid_i;
   logic        rx_err_i;
   logic        rx_ready_i;
   logic        tx_ready_i;
   logic [7:0]  tx_data_o;
   logic        tx_valid_o;
   logic [7:0]  out_data_o;
   logic        out_valid_o;
   logic        out_eop_o;
   logic        out_err_o;
   logic        setup_o;
   logic [3:0]  endp_o;
   logic [10:0] frame_o;
   logic [6:0]  addr_i;
   logic        stall_i;
   logic        out_nak_i;
   logic        out_toggle_reset_i;

   string       test_name;
   int          errs;
   int          total_errs;
   int          tests_run;
   int          tests_bad;
   int          cycle_cnt;
   int          seed = 17;
   logic [7:0]  exp_q[$];
   logic [7:0]  exp_b;

   usb_sie_top i_usb_sie_top (.*);

   always #5 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Run stopped after %0d cycles, DUT did not finish", cycle_cnt);
         $display("=== FAIL ===");
         $finish;
      end
   end

   // Every streamed byte must be the next expected payload byte.
   always @(negedge clk_i) begin
      if (rstn && out_valid_o) begin
         assert (exp_q.size() > 0) else begin
            $display("%s: byte %0h appeared on out_data_o with none expected",
                     test_name, out_data_o);
            errs++;
         end
         if (exp_q.size() > 0) begin
            exp_b = exp_q.pop_front();
            assert (out_data_o == exp_b) else begin
               $display("mismatch %s out_data: expected %0h actual %0h",
                        test_name, exp_b, out_data_o);
               errs++;
            end
         end
      end
   end

   task automatic check_val(input string what, input int expv, input int actv);
      assert (expv == actv) else begin
         $display("mismatch %s %s: expected %0h actual %0h", test_name, what, expv, actv);
         errs++;
      end
   endtask

   // Reference CRC5 field, inverted and bit reversed.
   function automatic logic [4:0] ref_crc5(input logic [10:0] bits);
      logic [4:0] r;
      logic [4:0] f;
      logic       fb;
      r = 5'h1F;
      for (int k = 0; k < 11; k++) begin
         fb = bits[k] ^ r[4];
         r  = {r[3:0], 1'b0} ^ (fb ? 5'h05 : 5'h00);
      end
      for (int k = 0; k < 5; k++) begin
         f[4-k] = ~r[k];
      end
      return f;
   endfunction

   function automatic logic [15:0] ref_crc16(input logic [7:0] b, input logic [15:0] r_in);
      logic [15:0] r;
      logic        fb;
      r = r_in;
      for (int k = 0; k < 8; k++) begin
         fb = b[k] ^ r[15];
         r  = {r[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
      end
      return r;
   endfunction

   task automatic rx_step(input logic [7:0] b);
      @(negedge clk_i);
      rx_data_i  = b;
      rx_valid_i = 1'b1;
      rx_ready_i = 1'b1;
      @(negedge clk_i);
      rx_ready_i = 1'b0;
      repeat (2) @(negedge clk_i);
   endtask

   // End strobe, then the handshake two cycles later; hs below zero means none.
   task automatic finish_packet(input int hs, input logic eop, input logic err);
      @(negedge clk_i);
      rx_valid_i = 1'b0;
      rx_ready_i = 1'b1;
      @(negedge clk_i);
      rx_ready_i = 1'b0;
      check_val("tx_valid early", 0, int'(tx_valid_o));
      @(negedge clk_i);
      check_val("tx_valid", int'(hs >= 0), int'(tx_valid_o));
      check_val("out_eop", int'(eop), int'(out_eop_o));
      check_val("out_err", int'(err), int'(out_err_o));
      check_val("bytes left", 0, exp_q.size());
      if (hs >= 0) begin
         check_val("tx_data", hs, int'(tx_data_o));
         @(negedge clk_i);
         tx_ready_i = 1'b1;
         @(negedge clk_i);
         tx_ready_i = 1'b0;
         check_val("tx_valid after ready", 0, int'(tx_valid_o));
      end
      repeat (2) @(negedge clk_i);
   endtask

   task automatic send_token(input logic [3:0] pid, input logic [10:0] pay, input logic bad);
      logic [4:0] f;
      f = ref_crc5(pay) ^ {4'b0000, bad};
      rx_step({~pid, pid});
      rx_step(pay[7:0]);
      rx_step({f, pay[10:8]});
      finish_packet(-1, 1'b0, 1'b0);
   endtask

   task automatic send_data(input logic [3:0] pid, input logic bad, input logic accepted,
                            input int hs, input logic eop, input logic err);
      logic [7:0]  pay[$];
      logic [15:0] r;
      logic [15:0] f;
      int          n;
      n = 1 + int'($unsigned($random(seed)) % 8);
      r = 16'hFFFF;
      for (int k = 0; k < n; k++) begin
         pay.push_back(8'($random(seed)));
         r = ref_crc16(pay[k], r);
         if (accepted) begin
            exp_q.push_back(pay[k]);
         end
      end
      for (int k = 0; k < 16; k++) begin
         f[k] = ~r[15-k];
      end
      rx_step({~pid, pid});
      foreach (pay[k]) begin
         rx_step(pay[k]);
      end
      rx_step(f[7:0] ^ {7'b0, bad});
      rx_step(f[15:8]);
      finish_packet(hs, eop, err);
   endtask

   task automatic end_test();
      $display("test %s: %s, %0d errors", test_name, (errs == 0) ? "ok" : "failed", errs);
      tests_run++;
      if (errs != 0) begin
         tests_bad++;
      end
      total_errs += errs;
      errs = 0;
   endtask

   initial begin
      rstn = 1'b0;
      rx_data_i = 8'h00;
      rx_valid_i = 1'b0;
      rx_err_i = 1'b0;
      rx_ready_i = 1'b0;
      tx_ready_i = 1'b0;
      addr_i = DEV_ADDR;
      stall_i = 1'b0;
      out_nak_i = 1'b0;
      out_toggle_reset_i = 1'b0;
      repeat (16) @(negedge clk_i);
      rstn = 1'b1;
      test_name = "reset";
      check_val("frame", 0, int'(frame_o));
      check_val("endp", int'(`USB_ENDP_CTRL), int'(endp_o));
      check_val("setup", 0, int'(setup_o));
      end_test();
      test_name = "sof";
      send_token(4'b0101, 11'h5A3, 1'b0);
      check_val("frame", 'h5A3, int'(frame_o));
      send_token(4'b0101, 11'h123, 1'b1);
      check_val("frame kept", 'h5A3, int'(frame_o));
      end_test();
      test_name = "bulk_out";
      send_token(4'b0001, {`USB_ENDP_BULK, DEV_ADDR}, 1'b0);
      send_data(4'b0011, 1'b0, 1'b1, 'hD2, 1'b1, 1'b0);
      send_token(4'b0001, {`USB_ENDP_BULK, DEV_ADDR}, 1'b0);
      send_data(4'b0011, 1'b0, 1'b1, 'hD2, 1'b0, 1'b1);
      @(negedge clk_i);
      out_toggle_reset_i = 1'b1;
      @(negedge clk_i);
      out_toggle_reset_i = 1'b0;
      send_token(4'b0001, {`USB_ENDP_BULK, DEV_ADDR}, 1'b0);
      send_data(4'b0011, 1'b0, 1'b1, 'hD2, 1'b1, 1'b0);
      end_test();
      test_name = "nak_stall";
      out_nak_i = 1'b1;
      send_token(4'b0001, {`USB_ENDP_BULK, DEV_ADDR}, 1'b0);
      send_data(4'b1011, 1'b0, 1'b1, 'h5A, 1'b1, 1'b0);
      out_nak_i = 1'b0;
      send_token(4'b0001, {`USB_ENDP_BULK, DEV_ADDR}, 1'b0);
      send_data(4'b1011, 1'b0, 1'b1, 'hD2, 1'b1, 1'b0);
      stall_i = 1'b1;
      send_token(4'b0001, {`USB_ENDP_BULK, DEV_ADDR}, 1'b0);
      send_data(4'b0011, 1'b0, 1'b1, 'h1E, 1'b1, 1'b0);
      stall_i = 1'b0;
      end_test();
      test_name = "setup";
      // Leaves the control toggle at one before the SETUP.
      send_token(4'b0001, {`USB_ENDP_CTRL, DEV_ADDR}, 1'b0);
      send_data(4'b0011, 1'b0, 1'b1, 'hD2, 1'b1, 1'b0);
      // Moves endp_o off the control endpoint.
      send_token(4'b0001, {`USB_ENDP_BULK, DEV_ADDR}, 1'b0);
      check_val("endp bulk", int'(`USB_ENDP_BULK), int'(endp_o));
      send_token(4'b1101, {`USB_ENDP_CTRL, DEV_ADDR}, 1'b0);
      check_val("setup", 1, int'(setup_o));
      check_val("endp", int'(`USB_ENDP_CTRL), int'(endp_o));
      send_data(4'b0011, 1'b0, 1'b1, 'hD2, 1'b1, 1'b0);
      send_token(4'b0001, {`USB_ENDP_CTRL, DEV_ADDR}, 1'b0);
      check_val("setup low", 0, int'(setup_o));
      end_test();
      test_name = "bad_crc16";
      send_token(4'b0001, {`USB_ENDP_BULK, DEV_ADDR}, 1'b0);
      send_data(4'b1011, 1'b1, 1'b1, -1, 1'b0, 1'b1);
      end_test();
      test_name = "ignored";
      send_token(4'b0001, {`USB_ENDP_BULK, DEV_ADDR ^ 7'h01}, 1'b0);
      send_data(4'b1011, 1'b0, 1'b0, -1, 1'b0, 1'b0);
      send_token(4'b0001, {`USB_ENDP_BULK, DEV_ADDR}, 1'b0);
      // PID byte with a broken check nibble.
      rx_step(8'hD3);
      rx_step(8'h55);
      rx_step(8'hAA);
      finish_packet(-1, 1'b0, 1'b0);
      end_test();
      $display("tests %0d, failed tests %0d, errors %0d", tests_run, tests_bad, total_errs);
      if (tests_bad == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

//--- usb_sie_top.f
+incdir+.
usb_sie_pkg.sv
usb_rx_packet.sv
usb_sie_ctrl.sv
usb_sie_top.sv
tb_usb_sie_top.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_usb_sie_top
FILELIST  = usb_sie_top.f
PASS_MSG  = === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
